/* verilog/ring_pkg.sv */
package ring_pkg;

   ////////////////////
   // widths
   localparam int NODE_W    = 10;   // node address and hop counter
   localparam int WORD_W    = 64;   // one stream beat
   localparam int KIND_W    = 2;
   localparam int CMD_ID_W  = 5;
   localparam int FLAGS_W   = 3;
   localparam int PAYLOAD_W = 24;

   ////////////////////
   // frame header, msb first on the wire word
   typedef struct packed {
      logic [KIND_W-1:0]    kind;
      logic [CMD_ID_W-1:0]  cmd_id;
      logic [FLAGS_W-1:0]   flags;
      logic [NODE_W-1:0]    dst;       // all ones is broadcast
      logic [NODE_W-1:0]    src;
      logic [NODE_W-1:0]    step;      // hop count, all ones ends the frame
      logic [PAYLOAD_W-1:0] payload;
   } ring_hdr_t;

   typedef union packed {
      logic [WORD_W-1:0] raw;
      ring_hdr_t         fields;
   } ring_hdr_u;

   // node sequencing
   typedef enum logic [2:0] {
      NOT_RDY, IDLE, RX, EXEC, FORWARD, SEND_H, SEND_D, WAIT_REL
   } node_state_e;

   // what to do with a received frame
   typedef enum logic [1:0] {
      RT_EXEC, RT_FORWARD, RT_DROP
   } ring_route_e;

endpackage

/* verilog/ring_rx_capture.sv */
`timescale 1ns/1ns
module ring_rx_capture (
   input  logic                        user_clk,
   input  logic                        ps_rst_ni,
   input  logic                        rx_valid_i,
   input  logic [ring_pkg::WORD_W-1:0] rx_data_i,
   input  logic                        rx_last_i,
   input  logic [ring_pkg::NODE_W-1:0] node_id_i,
   output logic                        frame_vld_o,
   output ring_pkg::ring_route_e       route_o,
   output ring_pkg::ring_hdr_u         hdr_o,
   output logic [ring_pkg::WORD_W-1:0] data_o
);

   ring_pkg::ring_hdr_u         hdr_q;
   logic [ring_pkg::WORD_W-1:0] data_q;
   logic                        hdr_beat;
   logic                        data_beat;
   logic                        last_step;
   logic                        dst_own;
   logic                        dst_all;
   logic                        src_own;
   ring_pkg::ring_route_e       route_d;

   assign hdr_beat  = rx_valid_i & ~rx_last_i;   // no back-pressure on rx
   assign data_beat = rx_valid_i &  rx_last_i;

   ////////////////////
   // beat storage
   always_ff @(posedge user_clk) begin
      if (hdr_beat) begin
         hdr_q.raw <= rx_data_i;
      end
      if (data_beat) begin
         data_q <= rx_data_i;
      end
   end

   ////////////////////
   // header decode, header is already stored when the data beat lands
   always_comb begin
      last_step = &hdr_q.fields.step;
      dst_own   = (|node_id_i) & (hdr_q.fields.dst == node_id_i);
      dst_all   = &hdr_q.fields.dst;
      src_own   = (hdr_q.fields.src == node_id_i);   // came all the way round
      if (last_step) begin
         route_d = ring_pkg::RT_DROP;
      end else if (dst_own | dst_all | src_own) begin
         route_d = ring_pkg::RT_EXEC;
      end else begin
         route_d = ring_pkg::RT_FORWARD;
      end
   end

   always_ff @(posedge user_clk or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         frame_vld_o <= 1'b0;
         route_o     <= ring_pkg::RT_DROP;
      end else begin
         frame_vld_o <= data_beat;         // one cycle after the data beat
         if (data_beat) begin
            route_o <= route_d;
         end
      end
   end

   assign hdr_o  = hdr_q;
   assign data_o = data_q;

endmodule

/* verilog/ring_tx_framer.sv */
`timescale 1ns/1ns
module ring_tx_framer (
   input  logic                        user_clk,
   input  logic                        ps_rst_ni,
   input  logic                        load_loc_i,
   input  logic                        load_fwd_i,
   input  ring_pkg::ring_hdr_u         loc_hdr_i,
   input  logic [ring_pkg::WORD_W-1:0] loc_data_i,
   input  ring_pkg::ring_hdr_u         fwd_hdr_i,
   input  logic [ring_pkg::WORD_W-1:0] fwd_data_i,
   input  logic                        send_hdr_i,
   input  logic                        send_data_i,
   input  logic                        tx_ready_i,
   output logic                        tx_valid_o,
   output logic [ring_pkg::WORD_W-1:0] tx_data_o,
   output logic                        tx_last_o,
   output logic                        beat_done_o
);

   ring_pkg::ring_hdr_u         fwd_hdr;
   ring_pkg::ring_hdr_u         hdr_buf;
   logic [ring_pkg::WORD_W-1:0] data_buf;
   logic                        send;
   logic                        start;

   ////////////////////
   // forwarded header, one more hop
   always_comb begin
      fwd_hdr             = fwd_hdr_i;
      fwd_hdr.fields.step = fwd_hdr_i.fields.step + 1'b1;
   end

   // frame buffer, local request or captured frame
   always_ff @(posedge user_clk) begin
      if (load_loc_i) begin
         hdr_buf  <= loc_hdr_i;
         data_buf <= loc_data_i;
      end else if (load_fwd_i) begin
         hdr_buf  <= fwd_hdr;
         data_buf <= fwd_data_i;   // data word travels untouched
      end
   end

   ////////////////////
   // beat output
   assign send        = send_hdr_i | send_data_i;
   assign start       = send & ~tx_valid_o;     // open a new beat
   assign beat_done_o = tx_valid_o & tx_ready_i;

   always_ff @(posedge user_clk or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         tx_valid_o <= 1'b0;
         tx_last_o  <= 1'b0;
      end else begin
         if (!send) begin
            // node left the send states, beat is withdrawn
            tx_valid_o <= 1'b0;
         end else if (beat_done_o) begin
            tx_valid_o <= 1'b0;
         end else if (start) begin
            tx_valid_o <= 1'b1;
            tx_last_o  <= send_data_i;   // data beat closes the frame
         end
      end
   end

   // held while waiting on ready
   always_ff @(posedge user_clk) begin
      if (start) begin
         tx_data_o <= send_data_i ? data_buf : hdr_buf.raw;
      end
   end

endmodule

/* verilog/ring_node_fsm.sv */
`timescale 1ns/1ns
module ring_node_fsm #(
   parameter int TIMEOUT_W = 9
) (
   input  logic                  user_clk,
   input  logic                  ps_rst_ni,
   input  logic                  channel_up_i,
   input  logic                  frame_vld_i,
   input  ring_pkg::ring_route_e route_i,
   input  logic                  tx_req_i,
   input  logic                  beat_done_i,
   output logic                  load_loc_o,
   output logic                  load_fwd_o,
   output logic                  send_hdr_o,
   output logic                  send_data_o,
   output logic                  cmd_req_o,
   output logic                  tx_ack_o,
   output logic                  ready_o
);

   ring_pkg::node_state_e state_q;
   ring_pkg::node_state_e state_d;
   logic [TIMEOUT_W-1:0]  time_cnt;
   logic                  busy;
   logic                  time_out;
   logic                  loc_q;        // frame in the framer is a local one
   logic                  ready_q;
   logic                  cmd_req_q;

   assign busy     = (state_q != ring_pkg::NOT_RDY) && (state_q != ring_pkg::IDLE);
   assign time_out = busy & (&time_cnt);   // last busy cycle before the limit

   ////////////////////
   // next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ring_pkg::NOT_RDY: begin
            if (channel_up_i) state_d = ring_pkg::IDLE;
         end
         ring_pkg::IDLE: begin
            if (frame_vld_i) begin
               state_d = ring_pkg::RX;          // received frame wins
            end else if (tx_req_i) begin
               state_d = ring_pkg::SEND_H;
            end
         end
         ring_pkg::RX: begin
            case (route_i)
               ring_pkg::RT_EXEC:    state_d = ring_pkg::EXEC;
               ring_pkg::RT_FORWARD: state_d = ring_pkg::FORWARD;
               default:              state_d = ring_pkg::IDLE;   // end of life
            endcase
         end
         ring_pkg::EXEC:    state_d = ring_pkg::IDLE;
         ring_pkg::FORWARD: state_d = ring_pkg::SEND_H;
         ring_pkg::SEND_H: begin
            if (beat_done_i) state_d = ring_pkg::SEND_D;
         end
         ring_pkg::SEND_D: begin
            if (beat_done_i) state_d = loc_q ? ring_pkg::WAIT_REL : ring_pkg::IDLE;
         end
         ring_pkg::WAIT_REL: begin
            if (!tx_req_i) state_d = ring_pkg::IDLE;
         end
         default: state_d = ring_pkg::NOT_RDY;
      endcase
      // link loss or a stuck transfer drops the node out of ready
      if (!channel_up_i || time_out) begin
         state_d = ring_pkg::NOT_RDY;
      end
   end

   ////////////////////
   // state and status registers
   always_ff @(posedge user_clk or negedge ps_rst_ni) begin
      if (!ps_rst_ni) begin
         state_q   <= ring_pkg::NOT_RDY;
         time_cnt  <= '0;
         loc_q     <= 1'b0;
         ready_q   <= 1'b0;
         cmd_req_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (!busy) begin
            time_cnt <= '0;
         end else begin
            time_cnt <= time_cnt + 1'b1;
         end
         if (load_loc_o) begin
            loc_q <= 1'b1;
         end else if (load_fwd_o) begin
            loc_q <= 1'b0;
         end
         ready_q   <= (state_q != ring_pkg::NOT_RDY);
         cmd_req_q <= (state_d == ring_pkg::EXEC);   // pulse while in EXEC
      end
   end

   // framer control
   assign load_loc_o  = (state_q == ring_pkg::IDLE) & ~frame_vld_i & tx_req_i;
   assign load_fwd_o  = (state_q == ring_pkg::FORWARD);
   assign send_hdr_o  = (state_q == ring_pkg::SEND_H);
   assign send_data_o = (state_q == ring_pkg::SEND_D);

   // only local frames reach WAIT_REL
   assign tx_ack_o  = (state_q == ring_pkg::WAIT_REL);
   assign cmd_req_o = cmd_req_q;
   assign ready_o   = ready_q;

endmodule

/* verilog/ring_node.sv */
`timescale 1ns/1ns
module ring_node #(
   parameter int TIMEOUT_W = 9
) (
   input  logic                        user_clk,
   input  logic                        ps_rst_ni,
   // input stream from the upstream neighbor
   input  logic                        rx_valid_i,
   input  logic [ring_pkg::WORD_W-1:0] rx_data_i,
   input  logic                        rx_last_i,
   // output stream to the downstream neighbor
   output logic                        tx_valid_o,
   output logic [ring_pkg::WORD_W-1:0] tx_data_o,
   output logic                        tx_last_o,
   input  logic                        tx_ready_i,
   // local transmit, four phase
   input  logic                        tx_req_i,
   input  logic [ring_pkg::WORD_W-1:0] tx_hdr_i,
   input  logic [ring_pkg::WORD_W-1:0] tx_data_i,
   output logic                        tx_ack_o,
   // commands for this node
   output logic                        cmd_req_o,
   output logic [ring_pkg::WORD_W-1:0] cmd_hdr_o,
   output logic [ring_pkg::WORD_W-1:0] cmd_data_o,
   // status
   input  logic                        channel_up_i,
   input  logic [ring_pkg::NODE_W-1:0] node_id_i,
   output logic                        ready_o
);

   logic                        frame_vld;
   ring_pkg::ring_route_e       route;
   ring_pkg::ring_hdr_u         hdr_q;
   logic [ring_pkg::WORD_W-1:0] data_q;
   logic                        load_loc;
   logic                        load_fwd;
   logic                        send_hdr;
   logic                        send_data;
   logic                        beat_done;

   ////////////////////
   // receive side
   ring_rx_capture u_capture (
      .user_clk    ( user_clk   ),
      .ps_rst_ni   ( ps_rst_ni  ),
      .rx_valid_i  ( rx_valid_i ),
      .rx_data_i   ( rx_data_i  ),
      .rx_last_i   ( rx_last_i  ),
      .node_id_i   ( node_id_i  ),
      .frame_vld_o ( frame_vld  ),
      .route_o     ( route      ),
      .hdr_o       ( hdr_q      ),
      .data_o      ( data_q     )
   );

   ////////////////////
   // transmit side
   ring_tx_framer u_framer (
      .user_clk    ( user_clk   ),
      .ps_rst_ni   ( ps_rst_ni  ),
      .load_loc_i  ( load_loc   ),
      .load_fwd_i  ( load_fwd   ),
      .loc_hdr_i   ( tx_hdr_i   ),   // raw word, read as fields inside
      .loc_data_i  ( tx_data_i  ),
      .fwd_hdr_i   ( hdr_q      ),
      .fwd_data_i  ( data_q     ),
      .send_hdr_i  ( send_hdr   ),
      .send_data_i ( send_data  ),
      .tx_ready_i  ( tx_ready_i ),
      .tx_valid_o  ( tx_valid_o ),
      .tx_data_o   ( tx_data_o  ),
      .tx_last_o   ( tx_last_o  ),
      .beat_done_o ( beat_done  )
   );

   ring_node_fsm #(
      .TIMEOUT_W ( TIMEOUT_W )
   ) u_fsm (
      .user_clk     ( user_clk     ),
      .ps_rst_ni    ( ps_rst_ni    ),
      .channel_up_i ( channel_up_i ),
      .frame_vld_i  ( frame_vld    ),
      .route_i      ( route        ),
      .tx_req_i     ( tx_req_i     ),
      .beat_done_i  ( beat_done    ),
      .load_loc_o   ( load_loc     ),
      .load_fwd_o   ( load_fwd     ),
      .send_hdr_o   ( send_hdr     ),
      .send_data_o  ( send_data    ),
      .cmd_req_o    ( cmd_req_o    ),
      .tx_ack_o     ( tx_ack_o     ),
      .ready_o      ( ready_o      )
   );

   // command words hold until the next capture
   assign cmd_hdr_o  = hdr_q.raw;
   assign cmd_data_o = data_q;

endmodule

/* verif/ring_node_chk.sv */
`timescale 1ns/1ns
module ring_node_chk (
   input logic                        user_clk,
   input logic                        ps_rst_ni,
   input logic                        tx_valid_o,
   input logic                        tx_ready_i,
   input logic [ring_pkg::WORD_W-1:0] tx_data_o,
   input logic                        tx_req_i,
   input logic                        tx_ack_o,
   input logic                        cmd_req_o
);

   ////////////////////
   // output stream
   data_hold: assert property (@(posedge user_clk) disable iff (!ps_rst_ni)
      (tx_valid_o && !tx_ready_i) |=> $stable(tx_data_o))   // stalled beat holds
      else $error("tx_data_o changed while the beat was stalled");

   ////////////////////
   // local transmit handshake
   ack_needs_req: assert property (@(posedge user_clk) disable iff (!ps_rst_ni)
      $rose(tx_ack_o) |-> tx_req_i)
      else $error("tx_ack_o rose with tx_req_i low");

   // command strobe
   cmd_single: assert property (@(posedge user_clk) disable iff (!ps_rst_ni)
      cmd_req_o |=> !cmd_req_o)
      else $error("cmd_req_o lasted more than one cycle");

endmodule

/* verif/ring_node_tb.sv */
`timescale 1ns/1ns
module ring_node_tb;

   localparam int         TIMEOUT_W = 9;
   localparam logic [9:0] NODE_ID   = 10'h0a5;

   logic                        user_clk;
   logic                        ps_rst_ni;
   logic                        rx_valid_i;
   logic [ring_pkg::WORD_W-1:0] rx_data_i;
   logic                        rx_last_i;
   logic                        tx_valid_o;
   logic [ring_pkg::WORD_W-1:0] tx_data_o;
   logic                        tx_last_o;
   logic                        tx_ready_i = 1'b1;
   logic                        tx_req_i;
   logic [ring_pkg::WORD_W-1:0] tx_hdr_i;
   logic [ring_pkg::WORD_W-1:0] tx_data_i;
   logic                        tx_ack_o;
   logic                        cmd_req_o;
   logic [ring_pkg::WORD_W-1:0] cmd_hdr_o;
   logic [ring_pkg::WORD_W-1:0] cmd_data_o;
   logic                        channel_up_i;
   logic [ring_pkg::NODE_W-1:0] node_id_i;
   logic                        ready_o;

   integer      seed;
   integer      bp_seed;
   int          err_cnt;
   int          tmo_cnt;
   int          cmd_cnt;
   logic        bp_rand;     // random ready when set
   logic        bp_level;    // ready level otherwise
   logic [64:0] beat_q[$];   // {last, data} of every transferred beat

   ring_node #(.TIMEOUT_W(TIMEOUT_W)) uut (.*);

   bind ring_node ring_node_chk u_chk (
      .user_clk   ( user_clk   ),
      .ps_rst_ni  ( ps_rst_ni  ),
      .tx_valid_o ( tx_valid_o ),
      .tx_ready_i ( tx_ready_i ),
      .tx_data_o  ( tx_data_o  ),
      .tx_req_i   ( tx_req_i   ),
      .tx_ack_o   ( tx_ack_o   ),
      .cmd_req_o  ( cmd_req_o  )
   );

   initial begin
      user_clk = 1'b0;
      forever #5 user_clk = ~user_clk;
   end

   ////////////////////
   // back-pressure and monitor
   always @(posedge user_clk) begin : bp_drive
      logic [31:0] r;
      r = $random(bp_seed);
      tx_ready_i <= bp_rand ? r[0] : bp_level;
   end

   always @(negedge user_clk) begin
      if (ps_rst_ni) begin
         if (tx_valid_o && tx_ready_i) beat_q.push_back({tx_last_o, tx_data_o});
         if (cmd_req_o) cmd_cnt++;
      end
   end

   ////////////////////
   // reference model
   function automatic ring_pkg::ring_route_e model_route(ring_pkg::ring_hdr_u h);
      if (h.fields.step == 10'h3ff) return ring_pkg::RT_DROP;
      if ((NODE_ID != 10'd0 && h.fields.dst == NODE_ID) || h.fields.dst == 10'h3ff ||
          h.fields.src == NODE_ID) return ring_pkg::RT_EXEC;
      return ring_pkg::RT_FORWARD;
   endfunction

   function automatic ring_pkg::ring_hdr_u model_fwd_hdr(ring_pkg::ring_hdr_u h);
      h.fields.step = h.fields.step + 10'd1;   // one more hop
      return h;
   endfunction

   function automatic logic [63:0] rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   // compare tasks
   task automatic check_hdr(string name, ring_pkg::ring_hdr_u exp, ring_pkg::ring_hdr_u act);
      if (exp !== act) begin
         err_cnt++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp.raw, act.raw);
      end
   endtask

   task automatic check_word(string name, logic [63:0] exp, logic [63:0] act);
      if (exp !== act) begin
         err_cnt++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (exp !== act) begin
         err_cnt++;
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic run_frame(string name, ring_pkg::ring_hdr_u h, logic [63:0] d);
      int          start_cmd;
      int          n;
      logic [64:0] b;
      ring_pkg::ring_route_e rt;
      rt        = model_route(h);
      start_cmd = cmd_cnt;
      @(posedge user_clk);
      rx_valid_i <= 1'b1;
      rx_data_i  <= h.raw;
      rx_last_i  <= 1'b0;
      @(posedge user_clk);
      rx_data_i  <= d;
      rx_last_i  <= 1'b1;
      @(posedge user_clk);
      rx_valid_i <= 1'b0;
      rx_last_i  <= 1'b0;
      if (rt == ring_pkg::RT_EXEC) begin
         n = 0;
         while (cmd_cnt == start_cmd && n < 50) begin
            @(negedge user_clk);
            n++;
         end
         if (cmd_cnt == start_cmd) begin
            tmo_cnt++;
            $display("%s: no command strobe for a frame addressed to this node", name);
         end else begin
            check_hdr(name, h, cmd_hdr_o);
            check_word(name, d, cmd_data_o);
         end
         repeat (4) @(negedge user_clk);   // settle window
      end else if (rt == ring_pkg::RT_FORWARD) begin
         n = 0;
         while (beat_q.size() < 2 && n < 300) begin
            @(negedge user_clk);
            n++;
         end
         if (beat_q.size() < 2) begin
            tmo_cnt++;
            $display("%s: forwarded frame did not come out on the stream", name);
         end else begin
            b = beat_q.pop_front();
            check_hdr(name, model_fwd_hdr(h), b[63:0]);
            check_bit(name, 1'b0, b[64]);
            b = beat_q.pop_front();
            check_word(name, d, b[63:0]);
            check_bit(name, 1'b1, b[64]);
         end
         @(negedge user_clk);
      end else begin
         repeat (100) @(negedge user_clk);   // nothing may appear here
      end
      if (beat_q.size() != 0) begin
         err_cnt++;
         $display("%s: unexpected beats on the output stream", name);
         beat_q.delete();
      end
      if (cmd_cnt != start_cmd + ((rt == ring_pkg::RT_EXEC) ? 1 : 0)) begin
         err_cnt++;
         $display("%s: wrong number of command strobes", name);
      end
   endtask

   task automatic local_send(string name, ring_pkg::ring_hdr_u h, logic [63:0] d);
      int          n;
      logic [64:0] b;
      @(posedge user_clk);
      tx_hdr_i  <= h.raw;
      tx_data_i <= d;
      tx_req_i  <= 1'b1;
      n = 0;
      while (!tx_ack_o && n < 600) begin
         @(negedge user_clk);
         n++;
      end
      if (!tx_ack_o || beat_q.size() != 2) begin
         tmo_cnt++;
         $display("%s: local frame not acknowledged after two beats", name);
         beat_q.delete();
      end else begin
         b = beat_q.pop_front();
         check_hdr(name, h, b[63:0]);
         check_bit(name, 1'b0, b[64]);
         b = beat_q.pop_front();
         check_word(name, d, b[63:0]);
         check_bit(name, 1'b1, b[64]);
         // ack stays up while the request is still held
         repeat (2) begin
            @(negedge user_clk);
            check_bit(name, 1'b1, tx_ack_o);
         end
      end
      @(posedge user_clk);
      tx_req_i <= 1'b0;
      n = 0;
      while (tx_ack_o && n < 20) begin
         @(negedge user_clk);
         n++;
      end
      if (tx_ack_o) begin
         tmo_cnt++;
         $display("%s: tx_ack_o stayed high after the request was dropped", name);
      end
   endtask

   ////////////////////
   // main sequence
   initial begin : main
      ring_pkg::ring_hdr_u h;
      int                  n;
      seed         = 32'h059c_3fb5;
      bp_seed      = 32'h059c_3fb5;
      err_cnt      = 0;
      tmo_cnt      = 0;
      cmd_cnt      = 0;
      bp_rand      = 1'b0;
      bp_level     = 1'b1;
      ps_rst_ni    = 1'b0;
      rx_valid_i   = 1'b0;
      rx_data_i    = '0;
      rx_last_i    = 1'b0;
      tx_req_i     = 1'b0;
      tx_hdr_i     = '0;
      tx_data_i    = '0;
      channel_up_i = 1'b1;
      node_id_i    = NODE_ID;
      repeat (16) @(posedge user_clk);
      ps_rst_ni <= 1'b1;

      @(negedge user_clk);
      check_bit("reset tx_valid", 1'b0, tx_valid_o);
      check_bit("reset tx_ack", 1'b0, tx_ack_o);
      check_bit("reset cmd_req", 1'b0, cmd_req_o);
      n = 0;
      while (!ready_o && n < 20) begin
         @(negedge user_clk);
         n++;
      end
      if (!ready_o) begin
         tmo_cnt++;
         $display("ready_o did not rise after reset");
      end

      // local commands for own id, broadcast and returned frames
      for (int i = 0; i < 12; i++) begin
         h.raw = rand_word();
         if (h.fields.step == 10'h3ff) h.fields.step = 10'd0;
         case (i % 3)
            0: h.fields.dst = NODE_ID;
            1: h.fields.dst = 10'h3ff;
            default: h.fields.src = NODE_ID;
         endcase
         run_frame("exec", h, rand_word());
      end

      bp_rand = 1'b1;
      for (int i = 0; i < 12; i++) begin
         h.raw = rand_word();
         while (model_route(h) != ring_pkg::RT_FORWARD) h.raw = rand_word();
         run_frame("forward", h, rand_word());
      end

      for (int i = 0; i < 4; i++) begin
         h.raw = rand_word();
         h.fields.step = 10'h3ff;   // end of life
         if (i[0]) h.fields.dst = NODE_ID;
         run_frame("drop", h, rand_word());
      end

      for (int i = 0; i < 8; i++) begin
         h.raw = rand_word();
         local_send("local", h, rand_word());
      end

      ////////////////////
      // leaving ready
      bp_rand = 1'b0;
      @(posedge user_clk);
      channel_up_i <= 1'b0;
      n = 0;
      while (ready_o && n < 10) begin
         @(negedge user_clk);
         n++;
      end
      if (ready_o) begin
         tmo_cnt++;
         $display("ready_o stayed high with the channel down");
      end
      @(posedge user_clk);
      channel_up_i <= 1'b1;
      n = 0;
      while (!ready_o && n < 10) begin
         @(negedge user_clk);
         n++;
      end
      if (!ready_o) begin
         tmo_cnt++;
         $display("ready_o did not return after the channel came up");
      end

      // stuck header beat runs into the timeout
      bp_level = 1'b0;
      @(posedge user_clk);
      tx_hdr_i  <= rand_word();
      tx_data_i <= rand_word();
      tx_req_i  <= 1'b1;
      n = 0;
      while (!tx_valid_o && n < 20) begin
         @(negedge user_clk);
         n++;
      end
      if (!tx_valid_o) begin
         tmo_cnt++;
         $display("header beat of the stalled local frame never appeared");
      end
      @(posedge user_clk);
      tx_req_i <= 1'b0;   // request abandoned while the FSM waits in SEND_H
      n = 0;
      while (ready_o && n < (1 << TIMEOUT_W) + 50) begin
         @(negedge user_clk);
         n++;
      end
      if (ready_o) begin
         tmo_cnt++;
         $display("ready_o stayed high with the output stream stuck");
      end else if (n < (1 << TIMEOUT_W) - 8) begin
         err_cnt++;
         $display("ready_o fell after %0d stalled cycles, before the timeout", n);
      end
      bp_level = 1'b1;
      n = 0;
      while (!ready_o && n < 20) begin
         @(negedge user_clk);
         n++;
      end
      if (!ready_o) begin
         tmo_cnt++;
         $display("ready_o did not return after the timeout");
      end
      check_bit("timeout tx_valid", 1'b0, tx_valid_o);
      check_bit("timeout tx_ack", 1'b0, tx_ack_o);
      if (beat_q.size() != 0) begin
         err_cnt++;
         $display("beats transferred while ready was held low");
      end

      $display("errors: %0d value, %0d timeout", err_cnt, tmo_cnt);
      if (err_cnt == 0 && tmo_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* ring_node.f */
verilog/ring_pkg.sv
verilog/ring_rx_capture.sv
verilog/ring_tx_framer.sv
verilog/ring_node_fsm.sv
verilog/ring_node.sv
verif/ring_node_chk.sv
verif/ring_node_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the ring node testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ring_node_tb \
   -f ring_node.f -o ring_node_sim
./obj_dir/ring_node_sim | tee sim.log

if grep -q "tests failed" sim.log; then
   exit 1
fi
exit 0
